// File: logic/i3c_target_pkg.sv
// Widths and types for an I3C SDR target that handles private transfers only, with no CCC or HDR
package i3c_target_pkg;

  localparam int unsigned AddrWidth = 7;
  localparam int unsigned ByteWidth = 8;

  // One-cycle bus condition pulses
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_event_t;

  // SCL edge pulses with the SDA level sampled alongside them
  typedef struct packed {
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } scl_edges_t;

  typedef struct packed {
    logic [AddrWidth-1:0] sta_addr;
    logic                 sta_valid;
    logic [AddrWidth-1:0] dyn_addr;
    logic                 dyn_valid;
  } target_cfg_t;

  typedef struct packed {
    logic [ByteWidth-1:0] data;
    logic                 parity_err;
  } rx_byte_t;

  typedef struct packed {
    logic [ByteWidth-1:0] data;
    logic                 last;
  } tx_byte_t;

  typedef enum logic [1:0] {
    ReqNone,
    ReqBit,
    ReqByte
  } bus_req_e;

  typedef enum logic [2:0] {
    Idle,
    Addr,
    AckAddr,
    WrByte,
    WrParity,
    RdByte,
    RdTbit,
    Wait
  } target_state_e;

endpackage

// File: logic/bus_monitor.sv
// SyncStages must be at least 2, and each SCL phase must last several clk_i cycles
`timescale 1ns/1ps

module bus_monitor #(
  parameter int unsigned SyncStages = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       enable_i,
  input  logic                       scl_i,
  input  logic                       sda_i,
  output i3c_target_pkg::scl_edges_t edges_o,
  output i3c_target_pkg::bus_event_t event_o
);

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic                  scl_s;
  logic                  sda_s;
  logic                  scl_prev_q;
  logic                  sda_prev_q;
  logic                  busy_q;
  logic                  start_det;
  logic                  stop_det;

  assign scl_s = scl_sync_q[SyncStages-1];
  assign sda_s = sda_sync_q[SyncStages-1];

  // SDA may only move while SCL is high for a START or a STOP
  assign start_det = enable_i & scl_s & scl_prev_q & sda_prev_q & ~sda_s;
  assign stop_det  = enable_i & scl_s & scl_prev_q & ~sda_prev_q & sda_s;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      busy_q     <= 1'b0;
      edges_o    <= '{scl_rise: 1'b0, scl_fall: 1'b0, sda: 1'b1};
      event_o    <= '0;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;

      edges_o.scl_rise <= enable_i & scl_s & ~scl_prev_q;
      edges_o.scl_fall <= enable_i & ~scl_s & scl_prev_q;
      edges_o.sda      <= sda_s;

      // A START before any STOP is a repeated START
      event_o.start  <= start_det & ~busy_q;
      event_o.rstart <= start_det & busy_q;
      event_o.stop   <= stop_det;

      if (!enable_i || stop_det) begin
        busy_q <= 1'b0;
      end else if (start_det) begin
        busy_q <= 1'b1;
      end
    end
  end

endmodule

// File: logic/bus_rx_flow.sv
// Requests are single-cycle pulses issued only after the previous done, and bytes arrive MSB first
`timescale 1ns/1ps

module bus_rx_flow (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  i3c_target_pkg::scl_edges_t           edges_i,
  input  i3c_target_pkg::bus_event_t           event_i,
  input  i3c_target_pkg::bus_req_e             req_i,
  output logic [i3c_target_pkg::ByteWidth-1:0] data_o,
  output logic                                 done_o
);
  import i3c_target_pkg::*;

  localparam int unsigned CntWidth = $clog2(ByteWidth);

  logic                 busy_q;
  logic                 byte_q;
  logic [CntWidth-1:0]  cnt_q;
  logic [ByteWidth-1:0] shift_q;
  logic                 load;
  logic                 abort;
  logic                 last_bit;

  assign load     = (req_i != ReqNone);
  assign abort    = |event_i;
  assign last_bit = byte_q ? (cnt_q == CntWidth'(ByteWidth - 1)) : 1'b1;
  assign done_o   = busy_q & edges_i.scl_rise & last_bit;

  // Current SDA already merged in so the data is complete with done
  assign data_o = {shift_q[ByteWidth-2:0], edges_i.sda};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      byte_q <= 1'b0;
      cnt_q  <= '0;
    end else if (load) begin
      busy_q <= 1'b1;
      byte_q <= (req_i == ReqByte);
      cnt_q  <= '0;
    end else if (abort || done_o) begin
      busy_q <= 1'b0;
    end else if (busy_q && edges_i.scl_rise) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= '0;
    end else if (busy_q && edges_i.scl_rise) begin
      shift_q <= data_o;
    end
  end

endmodule

// File: logic/bus_tx_flow.sv
// SdaHoldCycles must be at least 1 and shorter than the SCL low phase, and SCL is never stretched
`timescale 1ns/1ps

module bus_tx_flow #(
  parameter int unsigned SdaHoldCycles = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  i3c_target_pkg::scl_edges_t           edges_i,
  input  i3c_target_pkg::bus_event_t           event_i,
  input  i3c_target_pkg::bus_req_e             req_i,
  input  logic [i3c_target_pkg::ByteWidth-1:0] value_i,
  input  logic                                 push_pull_i,
  output logic                                 sda_o,
  output logic                                 sel_od_pp_o,
  output logic                                 done_o
);
  import i3c_target_pkg::*;

  localparam int unsigned HoldWidth = $clog2(SdaHoldCycles + 1);
  localparam int unsigned BitsWidth = $clog2(ByteWidth + 1);

  logic [HoldWidth-1:0] hold_q;
  logic                 busy_q;
  logic                 byte_q;
  logic [BitsWidth-1:0] bits_q;
  logic [BitsWidth-1:0] total;
  logic [ByteWidth-1:0] shift_q;
  logic [ByteWidth-1:0] first_word;
  logic                 sda_q;
  logic                 pp_q;
  logic                 load;
  logic                 present;
  logic                 remaining;

  assign load       = (req_i != ReqNone);
  assign first_word = (req_i == ReqByte) ? value_i : {value_i[0], {(ByteWidth - 1){1'b0}}};
  assign total      = byte_q ? BitsWidth'(ByteWidth) : BitsWidth'(1);
  assign remaining  = busy_q & (bits_q < total);

  // Cycle in which the next bit goes out, SdaHoldCycles after the fall pulse
  assign present = (SdaHoldCycles == 1) ? edges_i.scl_fall
                                        : (hold_q == HoldWidth'(SdaHoldCycles - 1));

  // Last bit has seen a full SCL high phase
  assign done_o = busy_q & edges_i.scl_fall & (bits_q == total);

  assign sda_o       = sda_q;
  assign sel_od_pp_o = pp_q;

  // Cycles since the last SCL fall, saturating
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= '0;
    end else if (edges_i.scl_fall) begin
      hold_q <= HoldWidth'(1);
    end else if (hold_q != '0 && hold_q != HoldWidth'(SdaHoldCycles)) begin
      hold_q <= hold_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      byte_q <= 1'b0;
      bits_q <= '0;
      sda_q  <= 1'b1;
      pp_q   <= 1'b0;
    end else if (load) begin
      busy_q <= 1'b1;
      byte_q <= (req_i == ReqByte);
      pp_q   <= push_pull_i;
      if (present) begin
        sda_q  <= first_word[ByteWidth-1];
        bits_q <= BitsWidth'(1);
      end else begin
        bits_q <= '0;
      end
    end else if (|event_i) begin
      busy_q <= 1'b0;
      sda_q  <= 1'b1;
      pp_q   <= 1'b0;
    end else begin
      if (done_o) begin
        busy_q <= 1'b0;
      end
      if (present) begin
        if (remaining) begin
          sda_q  <= shift_q[ByteWidth-1];
          bits_q <= bits_q + 1'b1;
        end else begin
          // Hand the line back after the hold time
          sda_q <= 1'b1;
          pp_q  <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= present ? (first_word << 1) : first_word;
    end else if (present && remaining) begin
      shift_q <= shift_q << 1;
    end
  end

endmodule

// File: logic/target_fsm.sv
// Private SDR transfers only; broadcast address and CCCs are not recognized and get no ACK
`timescale 1ns/1ps

module target_fsm (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 enable_i,
  input  i3c_target_pkg::target_cfg_t          cfg_i,
  input  i3c_target_pkg::bus_event_t           event_i,
  input  logic [i3c_target_pkg::ByteWidth-1:0] rx_data_i,
  input  logic                                 rx_done_i,
  input  logic                                 tx_done_i,
  input  logic                                 rx_full_i,
  input  logic                                 tx_valid_i,
  input  i3c_target_pkg::tx_byte_t             tx_byte_i,
  output i3c_target_pkg::bus_req_e             rx_req_o,
  output i3c_target_pkg::bus_req_e             tx_req_o,
  output logic [i3c_target_pkg::ByteWidth-1:0] tx_value_o,
  output logic                                 tx_push_pull_o,
  output logic [i3c_target_pkg::ByteWidth-1:0] addr_o,
  output logic                                 addr_valid_o,
  output logic                                 rx_valid_o,
  output i3c_target_pkg::rx_byte_t             rx_byte_o,
  output logic                                 rx_overflow_o,
  output logic                                 tx_ready_o
);
  import i3c_target_pkg::*;

  target_state_e        state_q;
  target_state_e        state_d;
  logic [AddrWidth-1:0] own_addr;
  logic                 own_valid;
  logic                 addr_match;
  logic                 addr_ack;
  logic                 addr_done;
  logic                 parity_done;
  logic                 more;
  logic                 rnw_q;
  logic                 tbit_q;
  logic                 last_q;
  logic                 addr_valid_q;
  logic                 rx_valid_q;
  logic                 rx_overflow_q;
  logic [ByteWidth-1:0] addr_q;
  logic [ByteWidth-1:0] wr_data_q;
  rx_byte_t             rx_byte_q;

  // Dynamic address wins once assigned
  assign own_addr   = cfg_i.dyn_valid ? cfg_i.dyn_addr : cfg_i.sta_addr;
  assign own_valid  = cfg_i.dyn_valid | cfg_i.sta_valid;
  assign addr_match = own_valid & (rx_data_i[ByteWidth-1:1] == own_addr);

  // A read is only acknowledged with data at hand
  assign addr_ack = addr_match & (~rx_data_i[0] | tx_valid_i);

  assign addr_done   = (state_q == Addr) & rx_done_i;
  assign parity_done = (state_q == WrParity) & rx_done_i;
  assign more        = ~last_q & tx_valid_i;

  always_comb begin
    state_d        = state_q;
    rx_req_o       = ReqNone;
    tx_req_o       = ReqNone;
    tx_value_o     = '0;
    tx_push_pull_o = 1'b0;
    tx_ready_o     = 1'b0;

    unique case (state_q)
      Addr: begin
        if (rx_done_i) begin
          if (addr_ack) begin
            state_d  = AckAddr;
            tx_req_o = ReqBit;
          end else begin
            state_d = Wait;
          end
        end
      end
      AckAddr: begin
        if (tx_done_i) begin
          if (!rnw_q) begin
            state_d  = WrByte;
            rx_req_o = ReqByte;
          end else if (tx_valid_i) begin
            state_d        = RdByte;
            tx_req_o       = ReqByte;
            tx_value_o     = tx_byte_i.data;
            tx_push_pull_o = 1'b1;
            tx_ready_o     = 1'b1;
          end else begin
            state_d = Wait;
          end
        end
      end
      WrByte: begin
        if (rx_done_i) begin
          state_d  = WrParity;
          rx_req_o = ReqBit;
        end
      end
      WrParity: begin
        if (rx_done_i) begin
          state_d  = WrByte;
          rx_req_o = ReqByte;
        end
      end
      RdByte: begin
        if (tx_done_i) begin
          state_d        = RdTbit;
          tx_req_o       = ReqBit;
          tx_value_o     = {{(ByteWidth - 1){1'b0}}, more};
          tx_push_pull_o = 1'b1;
        end
      end
      RdTbit: begin
        if (tx_done_i) begin
          if (tbit_q && tx_valid_i) begin
            state_d        = RdByte;
            tx_req_o       = ReqByte;
            tx_value_o     = tx_byte_i.data;
            tx_push_pull_o = 1'b1;
            tx_ready_o     = 1'b1;
          end else begin
            state_d = Wait;
          end
        end
      end
      default: ;
    endcase

    // Bus conditions override any transfer in progress
    if (event_i.start || event_i.rstart) begin
      state_d    = Addr;
      rx_req_o   = ReqByte;
      tx_req_o   = ReqNone;
      tx_ready_o = 1'b0;
    end else if (event_i.stop) begin
      state_d    = Idle;
      rx_req_o   = ReqNone;
      tx_req_o   = ReqNone;
      tx_ready_o = 1'b0;
    end

    if (!enable_i) begin
      state_d    = Idle;
      rx_req_o   = ReqNone;
      tx_req_o   = ReqNone;
      tx_ready_o = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      rnw_q         <= 1'b0;
      tbit_q        <= 1'b0;
      last_q        <= 1'b0;
      addr_valid_q  <= 1'b0;
      rx_valid_q    <= 1'b0;
      rx_overflow_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      addr_valid_q  <= addr_done;
      rx_valid_q    <= parity_done & ~rx_full_i;
      rx_overflow_q <= parity_done & rx_full_i;
      if (addr_done) begin
        rnw_q <= rx_data_i[0];
      end
      if (tx_ready_o) begin
        last_q <= tx_byte_i.last;
      end
      if (state_q == RdByte && tx_done_i) begin
        tbit_q <= more;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (addr_done) begin
      addr_q <= rx_data_i;
    end
    if (state_q == WrByte && rx_done_i) begin
      wr_data_q <= rx_data_i;
    end
    if (parity_done) begin
      rx_byte_q.data <= wr_data_q;
      // Odd parity over data and T bit
      rx_byte_q.parity_err <= (rx_data_i[0] == ^wr_data_q);
    end
  end

  assign addr_o        = addr_q;
  assign addr_valid_o  = addr_valid_q;
  assign rx_valid_o    = rx_valid_q;
  assign rx_byte_o     = rx_byte_q;
  assign rx_overflow_o = rx_overflow_q;

endmodule

// File: logic/i3c_target_top.sv
// The SCL pin is input only, and sda_o is meant for a wired-AND bus where 1 releases the line
`timescale 1ns/1ps

module i3c_target_top #(
  parameter int unsigned SyncStages    = 2,
  parameter int unsigned SdaHoldCycles = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 target_en_i,
  input  logic                                 scl_i,
  input  logic                                 sda_i,
  input  i3c_target_pkg::target_cfg_t          cfg_i,
  input  logic                                 rx_full_i,
  input  logic                                 tx_valid_i,
  input  i3c_target_pkg::tx_byte_t             tx_byte_i,
  output logic                                 sda_o,
  output logic                                 sel_od_pp_o,
  output i3c_target_pkg::bus_event_t           bus_event_o,
  output logic [i3c_target_pkg::ByteWidth-1:0] addr_o,
  output logic                                 addr_valid_o,
  output logic                                 rx_valid_o,
  output i3c_target_pkg::rx_byte_t             rx_byte_o,
  output logic                                 rx_overflow_o,
  output logic                                 tx_ready_o
);
  import i3c_target_pkg::*;

  scl_edges_t           edges;
  bus_req_e             rx_req;
  bus_req_e             tx_req;
  logic [ByteWidth-1:0] rx_data;
  logic [ByteWidth-1:0] tx_value;
  logic                 rx_done;
  logic                 tx_done;
  logic                 tx_push_pull;

  bus_monitor #(
    .SyncStages(SyncStages)
  ) bus_monitor_inst (
    .clk_i,
    .rst_ni,
    .enable_i(target_en_i),
    .scl_i,
    .sda_i,
    .edges_o (edges),
    .event_o (bus_event_o)
  );

  bus_rx_flow bus_rx_flow_inst (
    .clk_i,
    .rst_ni,
    .edges_i(edges),
    .event_i(bus_event_o),
    .req_i  (rx_req),
    .data_o (rx_data),
    .done_o (rx_done)
  );

  bus_tx_flow #(
    .SdaHoldCycles(SdaHoldCycles)
  ) bus_tx_flow_inst (
    .clk_i,
    .rst_ni,
    .edges_i    (edges),
    .event_i    (bus_event_o),
    .req_i      (tx_req),
    .value_i    (tx_value),
    .push_pull_i(tx_push_pull),
    .sda_o,
    .sel_od_pp_o,
    .done_o     (tx_done)
  );

  target_fsm target_fsm_inst (
    .clk_i,
    .rst_ni,
    .enable_i      (target_en_i),
    .cfg_i,
    .event_i       (bus_event_o),
    .rx_data_i     (rx_data),
    .rx_done_i     (rx_done),
    .tx_done_i     (tx_done),
    .rx_full_i,
    .tx_valid_i,
    .tx_byte_i,
    .rx_req_o      (rx_req),
    .tx_req_o      (tx_req),
    .tx_value_o    (tx_value),
    .tx_push_pull_o(tx_push_pull),
    .addr_o,
    .addr_valid_o,
    .rx_valid_o,
    .rx_byte_o,
    .rx_overflow_o,
    .tx_ready_o
  );

endmodule

// File: tb/host_tasks.svh
// Host bus tasks that need clk_i, scl, host_sda, sda_bus, bit_pp, exp_addr and compare in the includer

task automatic idle_clocks(input int n);
  repeat (n) @(posedge clk_i);
endtask

// One SCL period with 8 clocks per half, SDA set mid-low and sampled mid-high
task automatic clock_bit(input logic drive, output logic sampled);
  idle_clocks(4);
  host_sda <= drive;
  idle_clocks(4);
  scl <= 1'b1;
  idle_clocks(4);
  @(negedge clk_i);
  sampled = sda_bus;
  bit_pp  = sel_od_pp_o;
  idle_clocks(4);
  scl <= 1'b0;
endtask

// Serves as START from idle and as repeated START after a bit
task automatic start_cond();
  idle_clocks(4);
  host_sda <= 1'b1;
  idle_clocks(4);
  scl <= 1'b1;
  idle_clocks(8);
  host_sda <= 1'b0;
  idle_clocks(8);
  scl <= 1'b0;
endtask

task automatic stop_cond();
  idle_clocks(4);
  host_sda <= 1'b0;
  idle_clocks(4);
  scl <= 1'b1;
  idle_clocks(8);
  host_sda <= 1'b1;
  idle_clocks(8);
endtask

// Bit that makes the total count of ones odd
function automatic logic odd_parity_bit(input logic [ByteWidth-1:0] data);
  int ones;
  ones = 0;
  for (int i = 0; i < ByteWidth; i++) begin
    if (data[i]) begin
      ones++;
    end
  end
  return (ones % 2) == 0;
endfunction

task automatic address_phase(input logic [AddrWidth-1:0] addr, input logic rnw,
                             output logic ack_n);
  logic b;
  if (target_en_i) begin
    exp_addr.push_back({addr, rnw});
  end
  for (int i = AddrWidth - 1; i >= 0; i--) begin
    clock_bit(addr[i], b);
  end
  clock_bit(rnw, b);
  clock_bit(1'b1, ack_n);
  // ACK is open-drain
  if (!ack_n) begin
    compare("sel_od_pp_o", bit_pp, 1'b0);
  end
endtask

task automatic write_byte(input logic [ByteWidth-1:0] data, input logic flip_parity);
  logic b;
  for (int i = ByteWidth - 1; i >= 0; i--) begin
    clock_bit(data[i], b);
  end
  clock_bit(odd_parity_bit(data) ^ flip_parity, b);
endtask

task automatic read_byte(output logic [ByteWidth-1:0] data, output logic tbit);
  logic b;
  for (int i = ByteWidth - 1; i >= 0; i--) begin
    clock_bit(1'b1, b);
    data[i] = b;
    if (i == ByteWidth - 1) begin
      compare("sel_od_pp_o", bit_pp, 1'b1);
    end
  end
  clock_bit(1'b1, tbit);
endtask

// File: tb/tb_i3c_target.sv
// Host model at 16 clk_i cycles per SCL period for a DUT built with its default parameters
`timescale 1ns/1ps

module tb_i3c_target;
  import i3c_target_pkg::*;

  localparam int unsigned ResetCycles = 16;
  localparam int unsigned BitClocks   = 16;
  // Bus bits and START, repeated START and STOP conditions over all six tests
  localparam int unsigned BusBits     = 234;
  localparam int unsigned Conditions  = 17;
  localparam int unsigned TestGap     = 100;
  localparam int unsigned CycleLimit  =
    2 * (ResetCycles + BusBits * BitClocks + Conditions * 24 + 6 * TestGap);

  localparam logic [AddrWidth-1:0] StaAddr   = 7'h2a;
  localparam logic [AddrWidth-1:0] DynAddr   = 7'h35;
  localparam logic [AddrWidth-1:0] OtherAddr = 7'h11;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 target_en_i;
  logic                 scl;
  logic                 host_sda;
  logic                 sda_bus;
  target_cfg_t          cfg_i;
  logic                 rx_full_i;
  logic                 tx_valid_i;
  tx_byte_t             tx_byte_i;
  logic                 sda_o;
  logic                 sel_od_pp_o;
  bus_event_t           bus_event_o;
  logic [ByteWidth-1:0] addr_o;
  logic                 addr_valid_o;
  logic                 rx_valid_o;
  rx_byte_t             rx_byte_o;
  logic                 rx_overflow_o;
  logic                 tx_ready_o;

  rx_byte_t             exp_rx[$];
  logic [ByteWidth-1:0] exp_addr[$];
  tx_byte_t             tx_queue[$];
  tx_byte_t             exp_tx[$];
  logic [31:0]          rand_state;
  logic                 bit_pp;
  int                   errors;
  int                   checks;
  int                   tests_run;
  int                   test_err_base;
  int                   start_cnt;
  int                   rstart_cnt;
  int                   stop_cnt;
  int                   ovf_cnt;
  int                   pop_cnt;
  int unsigned          cycle_cnt;

  // Wired-AND bus
  assign sda_bus = host_sda & sda_o;

  i3c_target_top #(
    .SyncStages   (2),
    .SdaHoldCycles(2)
  ) i3c_target_top_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .target_en_i  (target_en_i),
    .scl_i        (scl),
    .sda_i        (sda_bus),
    .cfg_i        (cfg_i),
    .rx_full_i    (rx_full_i),
    .tx_valid_i   (tx_valid_i),
    .tx_byte_i    (tx_byte_i),
    .sda_o        (sda_o),
    .sel_od_pp_o  (sel_od_pp_o),
    .bus_event_o  (bus_event_o),
    .addr_o       (addr_o),
    .addr_valid_o (addr_valid_o),
    .rx_valid_o   (rx_valid_o),
    .rx_byte_o    (rx_byte_o),
    .rx_overflow_o(rx_overflow_o),
    .tx_ready_o   (tx_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  `include "host_tasks.svh"

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_random(output logic [ByteWidth-1:0] value);
    rand_state = xorshift32(rand_state);
    value      = rand_state[ByteWidth-1:0];
  endtask

  function automatic target_cfg_t build_cfg(input logic dyn_valid);
    target_cfg_t c;
    c.sta_addr  = StaAddr;
    c.sta_valid = 1'b1;
    c.dyn_addr  = DynAddr;
    c.dyn_valid = dyn_valid;
    return c;
  endfunction

  task automatic expect_rx(input logic [ByteWidth-1:0] data, input logic parity_err);
    rx_byte_t item;
    item.data       = data;
    item.parity_err = parity_err;
    exp_rx.push_back(item);
  endtask

  task automatic check_rx_byte();
    rx_byte_t exp;
    assert (exp_rx.size() != 0) else begin
      $display("rx_valid_o pulsed at %0t ns with no write byte outstanding", $time);
      errors++;
    end
    if (exp_rx.size() != 0) begin
      exp = exp_rx.pop_front();
      compare("rx_byte_o.data", rx_byte_o.data, exp.data);
      compare("rx_byte_o.parity_err", rx_byte_o.parity_err, exp.parity_err);
    end
  endtask

  task automatic check_addr();
    assert (exp_addr.size() != 0) else begin
      $display("addr_valid_o pulsed at %0t ns with no address phase outstanding", $time);
      errors++;
    end
    if (exp_addr.size() != 0) begin
      compare("addr_o", addr_o, exp_addr.pop_front());
    end
  endtask

  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    while ((exp_rx.size() != 0 || exp_addr.size() != 0) && waited < 64) begin
      @(posedge clk_i);
      waited++;
    end
    assert (exp_rx.size() == 0) else begin
      $display("%s: %0d write bytes never reached rx_byte_o", name, exp_rx.size());
      errors++;
    end
    assert (exp_addr.size() == 0) else begin
      $display("%s: %0d addresses never reported on addr_o", name, exp_addr.size());
      errors++;
    end
    exp_rx.delete();
    exp_addr.delete();
    tests_run++;
    $display("Test %0d %s: %0d errors", tests_run, name, errors - test_err_base);
    test_err_base = errors;
    idle_clocks(16);
  endtask

  // TX side behaves like a FIFO read port
  always @(posedge clk_i) begin
    tx_valid_i <= (tx_queue.size() != 0);
    tx_byte_i  <= (tx_queue.size() != 0) ? tx_queue[0] : '0;
  end

  always @(negedge clk_i) begin
    if (rst_ni) begin
      start_cnt  += bus_event_o.start;
      rstart_cnt += bus_event_o.rstart;
      stop_cnt   += bus_event_o.stop;
      if (rx_overflow_o) begin
        ovf_cnt++;
      end
      if (rx_valid_o) begin
        check_rx_byte();
      end
      if (addr_valid_o) begin
        check_addr();
      end
      if (tx_ready_o) begin
        pop_cnt++;
        assert (tx_queue.size() != 0) else begin
          $display("tx_ready_o pulsed at %0t ns with no byte offered", $time);
          errors++;
        end
        if (tx_queue.size() != 0) begin
          tx_queue.delete(0);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      $display("Timeout: the run exceeded %0d clock cycles", CycleLimit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin : stimulus
    logic [ByteWidth-1:0] d;
    logic                 ack_n;
    logic                 tbit;
    tx_byte_t             item;
    rst_ni        = 1'b0;
    target_en_i   = 1'b1;
    scl           = 1'b1;
    host_sda      = 1'b1;
    cfg_i         = build_cfg(1'b0);
    rx_full_i     = 1'b0;
    tx_valid_i    = 1'b0;
    tx_byte_i     = '0;
    rand_state    = 32'h362e;
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    test_err_base = 0;
    start_cnt     = 0;
    rstart_cnt    = 0;
    stop_cnt      = 0;
    ovf_cnt       = 0;
    pop_cnt       = 0;
    cycle_cnt     = 0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    compare("sda_o", sda_o, 1'b1);
    compare("sel_od_pp_o", sel_od_pp_o, 1'b0);
    compare("rx_valid_o", rx_valid_o, 1'b0);
    compare("tx_ready_o", tx_ready_o, 1'b0);
    compare("addr_valid_o", addr_valid_o, 1'b0);
    compare("rx_overflow_o", rx_overflow_o, 1'b0);
    compare("bus_event_o", bus_event_o, 3'b000);

    idle_clocks(4);
    start_cond();
    address_phase(StaAddr, 1'b0, ack_n);
    compare("sda_i (ACK)", ack_n, 1'b0);
    for (int i = 0; i < 5; i++) begin
      next_random(d);
      expect_rx(d, 1'b0);
      write_byte(d, 1'b0);
    end
    stop_cond();
    finish_test("static address write");

    // Static address is ignored once a dynamic one is valid
    cfg_i <= build_cfg(1'b1);
    idle_clocks(4);
    start_cond();
    address_phase(StaAddr, 1'b0, ack_n);
    compare("sda_i (ACK)", ack_n, 1'b1);
    next_random(d);
    write_byte(d, 1'b0);
    stop_cond();
    target_en_i <= 1'b0;
    idle_clocks(4);
    start_cond();
    address_phase(DynAddr, 1'b0, ack_n);
    compare("sda_i (ACK)", ack_n, 1'b1);
    next_random(d);
    write_byte(d, 1'b0);
    stop_cond();
    target_en_i <= 1'b1;
    finish_test("address mismatch and disabled target");

    start_cond();
    address_phase(DynAddr, 1'b0, ack_n);
    compare("sda_i (ACK)", ack_n, 1'b0);
    for (int i = 0; i < 3; i++) begin
      next_random(d);
      expect_rx(d, i == 1);
      write_byte(d, i == 1);
    end
    stop_cond();
    finish_test("parity error");

    for (int i = 0; i < 4; i++) begin
      next_random(d);
      item.data = d;
      item.last = (i == 3);
      tx_queue.push_back(item);
      exp_tx.push_back(item);
    end
    pop_cnt = 0;
    idle_clocks(4);
    start_cond();
    address_phase(DynAddr, 1'b1, ack_n);
    compare("sda_i (ACK)", ack_n, 1'b0);
    for (int i = 0; i < 4; i++) begin
      item = exp_tx[i];
      read_byte(d, tbit);
      compare("sda_o (read data)", d, item.data);
      compare("sda_o (T bit)", tbit, !item.last);
    end
    stop_cond();
    compare("tx_ready_o pulses", pop_cnt, 4);
    // Nothing left to send
    start_cond();
    address_phase(DynAddr, 1'b1, ack_n);
    compare("sda_i (ACK)", ack_n, 1'b1);
    stop_cond();
    exp_tx.delete();
    finish_test("private read");

    rx_full_i <= 1'b1;
    ovf_cnt = 0;
    start_cond();
    address_phase(DynAddr, 1'b0, ack_n);
    compare("sda_i (ACK)", ack_n, 1'b0);
    for (int i = 0; i < 3; i++) begin
      next_random(d);
      write_byte(d, 1'b0);
    end
    stop_cond();
    compare("rx_overflow_o pulses", ovf_cnt, 3);
    rx_full_i <= 1'b0;
    finish_test("receive overflow");

    cfg_i <= build_cfg(1'b0);
    start_cnt  = 0;
    rstart_cnt = 0;
    stop_cnt   = 0;
    idle_clocks(4);
    start_cond();
    address_phase(StaAddr, 1'b0, ack_n);
    compare("sda_i (ACK)", ack_n, 1'b0);
    start_cond();
    address_phase(OtherAddr, 1'b1, ack_n);
    compare("sda_i (ACK)", ack_n, 1'b1);
    stop_cond();
    compare("bus_event_o.start pulses", start_cnt, 1);
    compare("bus_event_o.rstart pulses", rstart_cnt, 1);
    compare("bus_event_o.stop pulses", stop_cnt, 1);
    finish_test("bus events and addresses");

    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+tb
logic/i3c_target_pkg.sv
logic/bus_monitor.sv
logic/bus_rx_flow.sv
logic/bus_tx_flow.sv
logic/target_fsm.sv
logic/i3c_target_top.sv
tb/tb_i3c_target.sv

// File: Bender.yml
package:
  name: i3c_target

sources:
  - logic/i3c_target_pkg.sv
  - logic/bus_monitor.sv
  - logic/bus_rx_flow.sv
  - logic/bus_tx_flow.sv
  - logic/target_fsm.sv
  - logic/i3c_target_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_i3c_target.sv
